// ==== bench/pov_clock_gen.sv ====
module pov_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_in,
    output logic rst_in
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2) clk_in = ~clk_in;
    end

    // release lands 2 ns after an edge, like the rest of the stimulus
    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        #2;
        rst_in = 1'b0;
    end

endmodule

// ==== bench/pov_frame_tb.sv ====
`include "pov_params.svh"

module pov_frame_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SWEEP_XFERS = 20 * `POV_SCAN;             // 20 sweeps per phase
    localparam int TOTAL_XFERS = 7 * SWEEP_XFERS + `POV_SCAN;
    localparam int XFER_CYCLES = 3 + 16;                     // refill gap + longest stall
    localparam int WATCHDOG_NS = 2 * 20 * (2 * 256 + TOTAL_XFERS * XFER_CYCLES);

    logic                clk_in;
    logic                rst_in;
    pov_pkg::angle_t     angle;
    pov_pkg::disp_mode_t mode;
    logic                clear;
    pov_pkg::fb_write_t  wr;
    logic                wr_valid;
    logic                wr_ready;
    pov_pkg::col_pair_t  out_pair;
    logic                out_valid;
    logic                out_ready;

    logic [31:0] lfsr_state = 32'h9676_7a71;
    int          stall_left;
    logic        long_stalls;   // phase 4 only
    logic        writes_on;
    logic        angle_walk;
    logic        mode_walk;     // mid-sweep mode changes
    int          writes_done;
    int          xfer_total;

    // reference model state
    logic                started;
    pov_pkg::pair_idx_t  exp_idx;       // index of the pair in flight
    pov_pkg::col_pair_t  exp_pair;
    pov_pkg::disp_mode_t sweep_mode_ref;
    pov_pkg::slot_t      sweep_slot_ref;
    pov_pkg::column_t    shadow [256];  // {slot, column}
    int                  clr_left;      // wipe cycles still to go
    logic                hold_q;
    pov_pkg::col_pair_t  held_pair;
    logic                gap1;
    logic                gap2;

    pov_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) u_clock_gen (
        .clk_in (clk_in),
        .rst_in (rst_in)
    );

    pov_frame_top u_pov_frame_top (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .angle     (angle),
        .mode      (mode),
        .clear     (clear),
        .wr        (wr),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .out_pair  (out_pair),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic logic pick_ready();
        if (stall_left > 0) begin
            stall_left--;
            return 1'b0;
        end
        if (long_stalls && take_bits(3) == 0) begin
            stall_left = take_bits(4);  // stretch of up to 15 more low cycles
            return 1'b0;
        end
        return take_bits(4) < 11;       // roughly 70 % high
    endfunction

    function automatic pov_pkg::column_t random_column();
        pov_pkg::column_t col;
        for (int r = 0; r < `POV_ROWS; r++) begin
            col[r] = pov_pkg::pixel_t'(take_bits(`POV_RGB_BITS));
        end
        return col;
    endfunction

    // one column as the display rules say it should look
    function automatic pov_pkg::column_t golden_column(
        input pov_pkg::col_idx_t   c,
        input pov_pkg::disp_mode_t m,
        input pov_pkg::slot_t      s
    );
        pov_pkg::column_t col;
        int               dr;
        int               dz;
        col = '0;
        dr  = 2 * int'(c) - 15;
        for (int r = 0; r < `POV_ROWS; r++) begin
            dz = 2 * r - 15;
            if (m == pov_pkg::MODE_CYLINDER && (dr == 15 || dr == -15)) begin
                col[r] = `POV_LIT;
            end else if (m == pov_pkg::MODE_SPHERE && dr * dr + dz * dz <= 225) begin
                col[r] = `POV_LIT;
            end
        end
        if (m == pov_pkg::MODE_BUFFER) begin
            col = shadow[{s, c}];   // whatever the host last wrote there
        end
        return col;
    endfunction

    function automatic pov_pkg::col_pair_t expected_pair(
        input pov_pkg::pair_idx_t  p,
        input pov_pkg::disp_mode_t m,
        input pov_pkg::slot_t      s
    );
        pov_pkg::col_pair_t cp;
        cp.col_lo = golden_column({1'b0, p}, m, s);  // column c
        cp.col_hi = golden_column({1'b1, p}, m, s);  // column c + 8
        cp.pair   = p;
        return cp;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // model of the sweep, the buffer contents and the wipe
    always @(posedge clk_in) begin : ref_model
        pov_pkg::pair_idx_t  nxt;
        pov_pkg::disp_mode_t m;
        pov_pkg::slot_t      s;
        if (rst_in) begin
            started  <= 1'b0;
            exp_idx  <= '0;
            clr_left <= 256;
            shadow   <= '{default: '0};
            hold_q   <= 1'b0;
            gap1     <= 1'b0;
            gap2     <= 1'b0;
        end else begin
            hold_q    <= out_valid && !out_ready;
            held_pair <= out_pair;
            gap1      <= out_valid && out_ready;
            gap2      <= gap1;
            // buffer read for the next pair starts on this edge
            if (!started || (out_valid && out_ready)) begin
                nxt = started ? exp_idx + 3'd1 : 3'd0;
                m   = sweep_mode_ref;
                s   = sweep_slot_ref;
                if (nxt == 3'd0) begin
                    m = mode;   // new sweep picks up angle and mode
                    s = angle[`POV_ANGLE_BITS-1 -: `POV_SLOT_BITS];
                end
                started        <= 1'b1;
                exp_idx        <= nxt;
                sweep_mode_ref <= m;
                sweep_slot_ref <= s;
                exp_pair       <= expected_pair(nxt, m, s);  // shadow before this write
            end
            if (clear) begin
                shadow   <= '{default: '0};
                clr_left <= 256;
            end else begin
                if (wr_valid && wr_ready) begin
                    shadow[{wr.slot, wr.col}] <= wr.data;
                end
                if (clr_left != 0) begin
                    clr_left <= clr_left - 1;
                end
            end
        end
    end

    a_pair_matches: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (out_valid && out_ready) |-> (out_pair == exp_pair)
    ) else report_mismatch($sformatf("pair %0d differs from reference", out_pair.pair));

    a_index_order: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_valid |-> (out_pair.pair == exp_idx)
    ) else report_mismatch($sformatf("pair index %0d, expected %0d", out_pair.pair, exp_idx));

    a_held_stable: assert property (
        @(posedge clk_in) disable iff (rst_in)
        hold_q |-> (out_valid && out_pair == held_pair)
    ) else report_mismatch("output pair changed under back-pressure");

    a_refill_gap: assert property (
        @(posedge clk_in) disable iff (rst_in)
        gap1 |-> !out_valid
    ) else report_mismatch("out_valid high in the cycle after a transfer");

    a_refill_next: assert property (
        @(posedge clk_in) disable iff (rst_in)
        gap2 |-> out_valid
    ) else report_mismatch("next pair not valid two cycles after a transfer");

    a_wipe_lockout: assert property (
        @(posedge clk_in) disable iff (rst_in)
        wr_ready == (clr_left == 0)
    ) else report_mismatch($sformatf("wr_ready %0b with %0d wipe cycles left",
                                     wr_ready, clr_left));

    // one clock, edge values sampled, inputs driven 2 ns later
    task automatic cycle_step(output logic xfer, output logic wr_free);
        logic wr_taken;
        @(posedge clk_in);
        xfer     = out_valid && out_ready;
        wr_free  = wr_ready;
        wr_taken = wr_valid && wr_ready;
        #2;
        out_ready = pick_ready();
        if (wr_taken) begin
            wr_valid = 1'b0;
            writes_done++;
        end
        if (writes_on && !wr_valid && take_bits(2) == 0) begin
            // half the writes aim at the slot on display
            wr.slot  = take_bits(1) != 0 ? angle[`POV_ANGLE_BITS-1 -: `POV_SLOT_BITS]
                                         : pov_pkg::slot_t'(take_bits(`POV_SLOT_BITS));
            wr.col   = pov_pkg::col_idx_t'(take_bits(4));
            wr.data  = random_column();
            wr_valid = 1'b1;
        end
        if (angle_walk && take_bits(4) == 0) begin
            angle = pov_pkg::angle_t'(take_bits(`POV_ANGLE_BITS));
        end
        if (mode_walk && take_bits(3) == 0) begin
            mode = pov_pkg::disp_mode_t'(2'(take_bits(2)));  // any point of the sweep
        end
    endtask

    task automatic run_transfers(input int n);
        int   done;
        logic xfer;
        logic wr_free;
        done = 0;
        while (done < n) begin
            cycle_step(xfer, wr_free);
            if (xfer) begin
                done++;
                xfer_total++;
            end
        end
    endtask

    task automatic wait_wipe_done();
        logic xfer;
        logic wr_free;
        wr_free = 1'b0;
        while (!wr_free) begin
            cycle_step(xfer, wr_free);
        end
    endtask

    initial begin : stimulus
        logic xfer;
        logic wr_free;
        angle       = '0;
        mode        = pov_pkg::MODE_CYLINDER;
        clear       = 1'b0;
        wr          = '0;
        wr_valid    = 1'b0;
        out_ready   = 1'b0;
        stall_left  = 0;
        long_stalls = 1'b0;
        writes_on   = 1'b0;
        angle_walk  = 1'b0;
        mode_walk   = 1'b0;
        writes_done = 0;
        xfer_total  = 0;
        wait (!rst_in);

        run_transfers(SWEEP_XFERS);                 // cylinder
        mode      = pov_pkg::MODE_SPHERE;
        writes_on = 1'b1;                           // fill the buffer meanwhile
        run_transfers(SWEEP_XFERS);
        mode       = pov_pkg::MODE_BUFFER;
        angle_walk = 1'b1;
        run_transfers(SWEEP_XFERS);
        long_stalls = 1'b1;                         // long ready stalls
        run_transfers(SWEEP_XFERS);
        long_stalls = 1'b0;

        // clear with a shape sweep on display, so no buffer read sees the wipe
        writes_on  = 1'b0;
        angle_walk = 1'b0;
        mode       = pov_pkg::MODE_CYLINDER;
        run_transfers(`POV_SCAN);
        cycle_step(xfer, wr_free);
        clear = 1'b1;
        cycle_step(xfer, wr_free);
        clear = 1'b0;
        wait_wipe_done();
        mode = pov_pkg::MODE_BUFFER;
        run_transfers(SWEEP_XFERS / 2);             // all zero now
        writes_on  = 1'b1;
        angle_walk = 1'b1;
        run_transfers(SWEEP_XFERS / 2);

        mode = pov_pkg::MODE_BLANK;
        run_transfers(SWEEP_XFERS);
        mode_walk = 1'b1;
        run_transfers(SWEEP_XFERS);

        $display("%0d pairs transferred, %0d writes accepted", xfer_total, writes_done);
        $display("NO ERRORS");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("TIMEOUT: run hung, no finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $fatal(1);
    end

endmodule

// ==== compile.f ====
+incdir+include
rtl/pov_pkg.sv
rtl/column_scheduler.sv
rtl/shape_column_gen.sv
rtl/rot_frame_buffer.sv
rtl/pov_frame_top.sv
bench/pov_clock_gen.sv
bench/pov_frame_tb.sv

// ==== include/pov_params.svh ====
`ifndef POV_PARAMS_SVH
`define POV_PARAMS_SVH

// panel geometry
`define POV_ROWS 16           // leds per radial column
`define POV_SCAN 8            // column pairs per sweep, 2x this many columns

// rotation
`define POV_ANGLE_BITS 10     // angle counter width, one turn = 1024 steps
`define POV_SLOT_BITS 4       // buffer slots, top bits of the angle

// colour
`define POV_RGB_BITS 9        // 3 bits per channel
`define POV_LIT 9'h1FF        // generated shapes are plain white

// column c pairs with column c + POV_SCAN
// slot index = angle[POV_ANGLE_BITS-1 -: POV_SLOT_BITS]
// buffer depth = slots * columns

`endif

// ==== rtl/column_scheduler.sv ====
`include "pov_params.svh"

module column_scheduler (
    input  logic                clk_in,
    input  logic                rst_in,
    input  pov_pkg::angle_t     angle,       // live angle, sampled at sweep start
    input  pov_pkg::disp_mode_t mode,        // requested mode, sampled at sweep start
    input  pov_pkg::col_pair_t  gen_pair,    // combinational shape pair
    input  pov_pkg::col_pair_t  fb_pair,     // buffer pair, 1 cycle behind rd_*
    output pov_pkg::pair_idx_t  rd_pair,
    output pov_pkg::slot_t      rd_slot,
    output pov_pkg::disp_mode_t sweep_mode,  // mode latched for this sweep
    output pov_pkg::col_pair_t  out_pair,
    output logic                out_valid,
    input  logic                out_ready
);

    pov_pkg::sched_state_t state;
    pov_pkg::sched_state_t state_n;
    pov_pkg::pair_idx_t    idx;           // pair being fetched / presented
    pov_pkg::pair_idx_t    idx_n;
    pov_pkg::slot_t        slot_q;        // slot for the whole sweep
    pov_pkg::disp_mode_t   mode_q;
    pov_pkg::slot_t        angle_slot;
    pov_pkg::col_pair_t    src_pair;
    logic                  sweep_start;
    logic                  xfer;

    assign xfer       = out_valid && out_ready;
    assign angle_slot = angle[`POV_ANGLE_BITS-1 -: `POV_SLOT_BITS];  // top bits

    // next state and next index
    always_comb begin
        state_n = state;
        idx_n   = idx;
        case (state)
            pov_pkg::S_IDLE: state_n = pov_pkg::S_FETCH;      // leaves right after reset
            pov_pkg::S_FETCH: state_n = pov_pkg::S_PRESENT;   // single settle cycle
            pov_pkg::S_PRESENT: begin
                if (xfer) begin
                    state_n = pov_pkg::S_FETCH;
                    idx_n   = idx + 1'b1;   // 7 wraps to 0
                end
            end
            default: state_n = pov_pkg::S_IDLE;
        endcase
    end

    // fetch entry at index 0 opens a new sweep
    assign sweep_start = (state_n == pov_pkg::S_FETCH) && (idx_n == '0);

    // read address runs one cycle ahead so fb_pair is ready during S_FETCH
    assign rd_pair    = idx_n;
    assign rd_slot    = sweep_start ? angle_slot : slot_q;
    assign sweep_mode = mode_q;

    // source select on the latched mode
    always_comb begin
        src_pair = gen_pair;        // cylinder, sphere
        case (mode_q)
            pov_pkg::MODE_BUFFER: src_pair = fb_pair;
            pov_pkg::MODE_BLANK: begin
                src_pair      = '0;
                src_pair.pair = idx;    // index still counts
            end
            default: src_pair = gen_pair;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state     <= pov_pkg::S_IDLE;
            idx       <= '0;
            out_valid <= 1'b0;
            slot_q    <= '0;
            mode_q    <= pov_pkg::MODE_BLANK;
        end else begin
            state <= state_n;
            idx   <= idx_n;
            if (sweep_start) begin
                slot_q <= angle_slot;
                mode_q <= mode;     // mid-sweep changes wait for index 0
            end
            if (state == pov_pkg::S_FETCH) begin
                out_valid <= 1'b1;
            end else if (xfer) begin
                out_valid <= 1'b0;
            end
        end
    end

    // output pair register, loaded once per pair
    always_ff @(posedge clk_in) begin
        if (state == pov_pkg::S_FETCH) begin
            out_pair <= src_pair;
        end
    end

    // back-pressure holds the pair unchanged
    a_hold_stable: assert property (
        @(posedge clk_in) disable iff (rst_in)
        out_valid && !out_ready |=> out_valid && $stable(out_pair)
    );

    // a transfer is followed by one gap cycle, then the next pair
    a_refill_2cyc: assert property (
        @(posedge clk_in) disable iff (rst_in)
        xfer |=> !out_valid ##1 out_valid
    );

endmodule

// ==== rtl/pov_frame_top.sv ====
module pov_frame_top (
    input  logic                clk_in,
    input  logic                rst_in,
    input  pov_pkg::angle_t     angle,
    input  pov_pkg::disp_mode_t mode,
    input  logic                clear,
    input  pov_pkg::fb_write_t  wr,
    input  logic                wr_valid,
    output logic                wr_ready,
    output pov_pkg::col_pair_t  out_pair,
    output logic                out_valid,
    input  logic                out_ready
);

    pov_pkg::pair_idx_t  rd_pair;      // next pair to fetch
    pov_pkg::slot_t      rd_slot;      // slot of the current sweep
    pov_pkg::disp_mode_t sweep_mode;   // latched mode for the generator
    pov_pkg::col_pair_t  gen_pair;
    pov_pkg::col_pair_t  fb_pair;

    // control, owns the output register
    column_scheduler u_scheduler (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .angle      (angle),
        .mode       (mode),
        .gen_pair   (gen_pair),
        .fb_pair    (fb_pair),
        .rd_pair    (rd_pair),
        .rd_slot    (rd_slot),
        .sweep_mode (sweep_mode),
        .out_pair   (out_pair),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // cylinder / sphere pixels, no clock
    shape_column_gen u_shapes (
        .pair     (rd_pair),
        .mode     (sweep_mode),
        .gen_pair (gen_pair)
    );

    // rotational frame buffer
    rot_frame_buffer u_fb (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .clear    (clear),
        .wr       (wr),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .rd_slot  (rd_slot),
        .rd_pair  (rd_pair),
        .fb_pair  (fb_pair)
    );

endmodule

// ==== rtl/pov_pkg.sv ====
`include "pov_params.svh"

package pov_pkg;

    typedef logic [`POV_ANGLE_BITS-1:0] angle_t;        // rotation angle
    typedef logic [`POV_SLOT_BITS-1:0] slot_t;          // angular slot of the buffer
    typedef logic [$clog2(`POV_SCAN)-1:0] pair_idx_t;   // 0..7
    typedef logic [$clog2(2*`POV_SCAN)-1:0] col_idx_t;  // 0..15
    typedef logic [`POV_RGB_BITS-1:0] pixel_t;

    // row r of a column sits at index r
    typedef pixel_t [`POV_ROWS-1:0] column_t;

    typedef enum logic [1:0] {
        MODE_CYLINDER = 2'd0,   // outer shell only
        MODE_SPHERE   = 2'd1,   // round silhouette
        MODE_BUFFER   = 2'd2,   // rotational frame buffer
        MODE_BLANK    = 2'd3    // all dark
    } disp_mode_t;

    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_FETCH   = 2'd1,   // source settles, pair gets registered
        S_PRESENT = 2'd2    // pair on the bus until taken
    } sched_state_t;

    // two columns streamed per step
    typedef struct packed {
        column_t   col_lo;  // column c
        column_t   col_hi;  // column c + 8
        pair_idx_t pair;
    } col_pair_t;

    typedef struct packed {
        slot_t    slot;
        col_idx_t col;
        column_t  data;
    } fb_write_t;

endpackage

// ==== rtl/rot_frame_buffer.sv ====
`include "pov_params.svh"

module rot_frame_buffer (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               clear,       // one cycle starts a wipe
    input  pov_pkg::fb_write_t wr,
    input  logic               wr_valid,
    output logic               wr_ready,    // low while wiping
    input  pov_pkg::slot_t     rd_slot,
    input  pov_pkg::pair_idx_t rd_pair,
    output pov_pkg::col_pair_t fb_pair      // 1 cycle read latency
);

    localparam int COLS  = 2 * `POV_SCAN;
    localparam int DEPTH = (1 << `POV_SLOT_BITS) * COLS;  // 256 entries
    localparam int AW    = $clog2(DEPTH);

    // address = {slot, column}
    pov_pkg::column_t mem [DEPTH];

    logic [AW-1:0] clr_cnt;     // wipe pointer
    logic          clr_busy;
    logic          wr_fire;
    logic [AW-1:0] wr_addr;
    logic [AW-1:0] rd_addr_lo;
    logic [AW-1:0] rd_addr_hi;

    assign wr_ready   = !clr_busy;
    assign wr_fire    = wr_valid && wr_ready;
    assign wr_addr    = {wr.slot, wr.col};
    assign rd_addr_lo = {rd_slot, 1'b0, rd_pair};  // column c
    assign rd_addr_hi = {rd_slot, 1'b1, rd_pair};  // column c + 8

    // wipe sequencer steps one entry per cycle
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            clr_busy <= 1'b1;   // memory is wiped after every reset
            clr_cnt  <= '0;
        end else if (clear) begin
            clr_busy <= 1'b1;   // restart from entry 0
            clr_cnt  <= '0;
        end else if (clr_busy) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (&clr_cnt) begin
                clr_busy <= 1'b0;   // last entry done
            end
        end
    end

    // single write port shared by wipe and host writes
    always_ff @(posedge clk_in) begin
        if (clr_busy) begin
            mem[clr_cnt] <= '0;
        end else if (wr_fire) begin
            mem[wr_addr] <= wr.data;
        end
    end

    // registered dual read with one slot for both halves
    // a write lands before any read issued on a later cycle
    always_ff @(posedge clk_in) begin
        fb_pair.col_lo <= mem[rd_addr_lo];
        fb_pair.col_hi <= mem[rd_addr_hi];
        fb_pair.pair   <= rd_pair;
    end

    // writes still locked out when the wipe reaches its last entry
    a_no_wr_in_clear: assert property (
        @(posedge clk_in) disable iff (rst_in)
        clear |-> ##DEPTH !wr_ready
    );

endmodule

// ==== rtl/shape_column_gen.sv ====
`include "pov_params.svh"

module shape_column_gen (
    input  pov_pkg::pair_idx_t  pair,      // pair being fetched
    input  pov_pkg::disp_mode_t mode,      // latched sweep mode
    output pov_pkg::col_pair_t  gen_pair
);

    // offsets are doubled so the panel centre falls on an integer
    localparam int COL_SPAN = 2 * `POV_SCAN - 1;   // 15, dr of the outer column
    localparam int ROW_SPAN = `POV_ROWS - 1;       // 15, dz of the top row
    localparam int R_SQ     = COL_SPAN * COL_SPAN; // 225, silhouette radius squared

    // one full column of generated pixels
    function automatic pov_pkg::column_t shape_col(
        input pov_pkg::col_idx_t   c,
        input pov_pkg::disp_mode_t m
    );
        pov_pkg::column_t col;
        int               dr;
        int               dz;
        col = '0;
        dr  = 2 * int'(c) - COL_SPAN;      // -15..15 across the panel
        for (int r = 0; r < `POV_ROWS; r++) begin
            dz = 2 * r - ROW_SPAN;           // -15 bottom .. 15 top
            case (m)
                pov_pkg::MODE_CYLINDER: begin
                    // outermost columns only, all rows
                    if (dr == COL_SPAN || dr == -COL_SPAN) begin
                        col[r] = `POV_LIT;
                    end
                end
                pov_pkg::MODE_SPHERE: begin
                    if (dr * dr + dz * dz <= R_SQ) begin
                        col[r] = `POV_LIT;   // inside circle
                    end
                end
                default: col[r] = '0;        // buffer and blank come from elsewhere
            endcase
        end
        return col;
    endfunction

    pov_pkg::col_idx_t col_lo_idx;
    pov_pkg::col_idx_t col_hi_idx;

    assign col_lo_idx = {1'b0, pair};   // column c
    assign col_hi_idx = {1'b1, pair};   // column c + 8

    always_comb begin
        gen_pair.col_lo = shape_col(col_lo_idx, mode);
        gen_pair.col_hi = shape_col(col_hi_idx, mode);
        gen_pair.pair   = pair;         // echoed for the consumer
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the frame path testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module pov_frame_tb -o pov_frame_sim

# the log decides, not the exit code of the simulator
./obj_dir/pov_frame_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation passed"
